// File: source/mipsExecPkg.sv
`default_nettype none

package mipsExecPkg;

        typedef logic [4:0] aluOpCode;

        // One instruction word, read as R-type or I-type fields
        typedef union packed {
                struct packed {
                        logic [5:0] opcode;
                        logic [4:0] rs;
                        logic [4:0] rt;
                        logic [4:0] rd;
                        logic [4:0] shamt;
                        logic [5:0] funct;
                } rType;
                struct packed {
                        logic [5:0]  opcode;
                        logic [4:0]  rs;
                        logic [4:0]  rt;
                        logic [15:0] imm;
                } iType;
        } instrWord;

        //////////////////////////////////////////////////////////////////////
        // ALU operation codes
        //////////////////////////////////////////////////////////////////////
        localparam aluOpCode opAdd   = 5'd0;
        localparam aluOpCode opSub   = 5'd1;
        localparam aluOpCode opMul   = 5'd2;
        localparam aluOpCode opAnd   = 5'd3;
        localparam aluOpCode opOr    = 5'd4;
        localparam aluOpCode opXor   = 5'd5;
        localparam aluOpCode opNor   = 5'd6;
        localparam aluOpCode opSll   = 5'd7;
        localparam aluOpCode opSrl   = 5'd8;
        localparam aluOpCode opRotr  = 5'd9;
        localparam aluOpCode opSra   = 5'd10;
        localparam aluOpCode opSeh   = 5'd11;
        localparam aluOpCode opAddu  = 5'd12;
        localparam aluOpCode opSlt   = 5'd14;
        localparam aluOpCode opSeb   = 5'd15;
        localparam aluOpCode opSltu  = 5'd16;
        localparam aluOpCode opSllv  = 5'd17;
        localparam aluOpCode opSrlv  = 5'd18;
        localparam aluOpCode opSrav  = 5'd19;
        localparam aluOpCode opRotrv = 5'd20;
        localparam aluOpCode opPassA = 5'd21;
        localparam aluOpCode opLui   = 5'd22;

        // Byte offsets in the APB register window
        localparam logic [7:0] regInstr  = 8'h00;
        localparam logic [7:0] regOpA    = 8'h04;
        localparam logic [7:0] regOpB    = 8'h08;
        localparam logic [7:0] regCmd    = 8'h0C;
        localparam logic [7:0] regResult = 8'h10;
        localparam logic [7:0] regStatus = 8'h14;

endpackage

`default_nettype wire

// File: source/aluController.sv
`timescale 1ns/100ps
`default_nettype none

module aluController (
        input  mipsExecPkg::instrWord instr,
        output mipsExecPkg::aluOpCode aluOp,
        output logic                  useImm,
        output logic                  zeroExt,
        output logic                  illegal
);
        import mipsExecPkg::*;

        // I-type ALU group is opcodes 0x08 to 0x0F
        assign useImm  = (instr.iType.opcode[5:3] == 3'b001);
        // andi, ori, xori take a zero-extended immediate
        assign zeroExt = (instr.iType.opcode == 6'h0C) || (instr.iType.opcode == 6'h0D) ||
                         (instr.iType.opcode == 6'h0E);

        always_comb begin
                aluOp   = opAdd;
                illegal = 1'b0;
                case (instr.rType.opcode)
                        // SPECIAL, decoded by funct
                        6'h00: begin
                                case (instr.rType.funct)
                                        6'h00: aluOp = opSll;
                                        6'h02: begin
                                                // rs bit picks srl or rotr
                                                if (instr.rType.rs == 5'd0)
                                                        aluOp = opSrl;
                                                else if (instr.rType.rs == 5'd1)
                                                        aluOp = opRotr;
                                                else
                                                        illegal = 1'b1;
                                        end
                                        6'h03: aluOp = opSra;
                                        6'h04: aluOp = opSllv;
                                        6'h06: begin
                                                // shamt bit picks srlv or rotrv
                                                if (instr.rType.shamt == 5'd0)
                                                        aluOp = opSrlv;
                                                else if (instr.rType.shamt == 5'd1)
                                                        aluOp = opRotrv;
                                                else
                                                        illegal = 1'b1;
                                        end
                                        6'h07: aluOp = opSrav;
                                        6'h20: aluOp = opAdd;
                                        6'h21: aluOp = opAddu;
                                        6'h22: aluOp = opSub;
                                        6'h24: aluOp = opAnd;
                                        6'h25: aluOp = opOr;
                                        6'h26: aluOp = opXor;
                                        6'h27: aluOp = opNor;
                                        6'h2A: aluOp = opSlt;
                                        6'h2B: aluOp = opSltu;
                                        // mult, multu, movn, movz, mthi, mtlo land here
                                        default: illegal = 1'b1;
                                endcase
                        end
                        // REGIMM, only bltz and bgez
                        6'h01: begin
                                if (instr.iType.rt == 5'd0 || instr.iType.rt == 5'd1)
                                        aluOp = opPassA;
                                else
                                        illegal = 1'b1;
                        end
                        6'h04, 6'h05: aluOp = opSub;
                        6'h06, 6'h07: begin
                                if (instr.iType.rt == 5'd0)
                                        aluOp = opPassA;
                                else
                                        illegal = 1'b1;
                        end
                        6'h08: aluOp = opAdd;
                        6'h09: aluOp = opAddu;
                        6'h0A: aluOp = opSlt;
                        6'h0B: aluOp = opSltu;
                        6'h0C: aluOp = opAnd;
                        6'h0D: aluOp = opOr;
                        6'h0E: aluOp = opXor;
                        6'h0F: aluOp = opLui;
                        // SPECIAL2 mul
                        6'h1C: begin
                                if (instr.rType.funct == 6'h02 && instr.rType.shamt == 5'd0)
                                        aluOp = opMul;
                                else
                                        illegal = 1'b1;
                        end
                        // SPECIAL3 BSHFL, shamt selects seb or seh
                        6'h1F: begin
                                if (instr.rType.funct == 6'h20 && instr.rType.shamt == 5'h10)
                                        aluOp = opSeb;
                                else if (instr.rType.funct == 6'h20 &&
                                         instr.rType.shamt == 5'h18)
                                        aluOp = opSeh;
                                else
                                        illegal = 1'b1;
                        end
                        default: illegal = 1'b1;
                endcase
        end

endmodule

`default_nettype wire

// File: source/aluCore.sv
`timescale 1ns/100ps
`default_nettype none

module aluCore (
        input  mipsExecPkg::instrWord instr,
        input  logic [31:0]           opA,
        input  logic [31:0]           opB,
        input  mipsExecPkg::aluOpCode aluOp,
        input  logic                  useImm,
        input  logic                  zeroExt,
        output logic [31:0]           result
);
        import mipsExecPkg::*;

        logic [31:0] immExt;
        logic [31:0] srcB;
        logic [4:0]  varAmt;
        logic [63:0] rotFixed;
        logic [63:0] rotVar;

        assign immExt = zeroExt ? {16'h0000, instr.iType.imm} :
                                  {{16{instr.iType.imm[15]}}, instr.iType.imm};
        assign srcB   = useImm ? immExt : opB;

        // Variable shifts take the amount from rs
        assign varAmt = opA[4:0];

        // Rotate as a shift of the doubled word
        assign rotFixed = {opB, opB} >> instr.rType.shamt;
        assign rotVar   = {opB, opB} >> varAmt;

        always_comb begin
                case (aluOp)
                        opAdd, opAddu: result = opA + srcB;
                        opSub:         result = opA - srcB;
                        opMul:         result = opA * srcB;
                        opAnd:         result = opA & srcB;
                        opOr:          result = opA | srcB;
                        opXor:         result = opA ^ srcB;
                        opNor:         result = ~(opA | srcB);
                        opSlt:         result = {31'd0, $signed(opA) < $signed(srcB)};
                        opSltu:        result = {31'd0, opA < srcB};

                        // Fixed shifts, value in rt
                        opSll:         result = opB << instr.rType.shamt;
                        opSrl:         result = opB >> instr.rType.shamt;
                        opSra:         result = $signed(opB) >>> instr.rType.shamt;
                        opRotr:        result = rotFixed[31:0];

                        opSllv:        result = opB << varAmt;
                        opSrlv:        result = opB >> varAmt;
                        opSrav:        result = $signed(opB) >>> varAmt;
                        opRotrv:       result = rotVar[31:0];

                        // Extends and immediates
                        opSeb:         result = {{24{opB[7]}}, opB[7:0]};
                        opSeh:         result = {{16{opB[15]}}, opB[15:0]};
                        opLui:         result = {instr.iType.imm, 16'h0000};
                        opPassA:       result = opA;
                        default:       result = 32'd0;
                endcase
        end

endmodule

`default_nettype wire

// File: source/branchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module branchUnit (
        input  mipsExecPkg::instrWord instr,
        input  logic [31:0]           opA,
        input  logic [31:0]           opB,
        output logic                  taken
);
        import mipsExecPkg::*;

        always_comb begin
                taken = 1'b0;
                case (instr.iType.opcode)
                        // bltz when rt is 0, bgez when rt is 1
                        6'h01: begin
                                if (instr.iType.rt == 5'd0)
                                        taken = $signed(opA) < 32'sd0;
                                else if (instr.iType.rt == 5'd1)
                                        taken = $signed(opA) >= 32'sd0;
                        end
                        6'h04: taken = (opA == opB);
                        6'h05: taken = (opA != opB);
                        6'h06: taken = $signed(opA) <= 32'sd0;
                        6'h07: taken = $signed(opA) > 32'sd0;
                        default: taken = 1'b0;
                endcase
        end

endmodule

`default_nettype wire

// File: source/execCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module execCtrl #(
        parameter int addrWidth = 8
) (
        input  logic                  clk,
        input  logic                  rstN,
        input  logic                  psel,
        input  logic                  penable,
        input  logic                  pwrite,
        input  logic [addrWidth-1:0]  paddr,
        input  logic [31:0]           pwdata,
        output logic [31:0]           prdata,
        output logic                  pready,
        output logic                  pslverr,
        input  logic [31:0]           result,
        input  logic                  taken,
        input  logic                  illegal,
        output mipsExecPkg::instrWord instr,
        output logic [31:0]           opA,
        output logic [31:0]           opB
);
        import mipsExecPkg::*;

        logic [7:0]  offset;
        logic        access;
        logic        upperBad;
        logic        mapped;
        logic        addrErr;
        logic        resultRead;
        logic        errWrite;
        logic        errRead;
        logic        stall;
        logic        wrEn;
        logic        cmdWrite;
        logic        busy;
        logic        done;
        logic [31:0] resultReg;
        logic        takenReg;
        logic        illegalReg;
        logic [31:0] readData;

        //////////////////////////////////////////////////////////////////////
        // Address decode
        //////////////////////////////////////////////////////////////////////
        assign offset   = paddr[7:0];
        assign access   = psel && penable;
        assign upperBad = (paddr >> 8) != '0;

        always_comb begin
                mapped   = 1'b1;
                readData = 32'd0;
                case (offset)
                        regInstr:  readData = instr;
                        regOpA:    readData = opA;
                        regOpB:    readData = opB;
                        regCmd:    readData = 32'd0;
                        regResult: readData = resultReg;
                        regStatus: readData = {29'd0, illegalReg, takenReg, done};
                        default:   mapped = 1'b0;
                endcase
        end

        assign addrErr    = upperBad || !mapped;
        assign resultRead = (offset == regResult) || (offset == regStatus);

        // Operand registers are locked while an execution is in flight
        assign errWrite = addrErr || resultRead ||
                          (busy && (offset inside {regInstr, regOpA, regOpB}));
        assign errRead  = addrErr || (offset == regCmd);

        // One wait state for a result read during execution
        assign stall   = access && !pwrite && busy && resultRead && !addrErr;
        assign pready  = !stall;
        assign pslverr = access && (pwrite ? errWrite : errRead);
        assign prdata  = (access && !pwrite && pready && !errRead) ? readData : 32'd0;

        assign wrEn     = access && pwrite && !errWrite;
        assign cmdWrite = wrEn && (offset == regCmd);

        //////////////////////////////////////////////////////////////////////
        // Registers and sequencing
        //////////////////////////////////////////////////////////////////////
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        instr      <= '0;
                        opA        <= 32'd0;
                        opB        <= 32'd0;
                        busy       <= 1'b0;
                        done       <= 1'b0;
                        resultReg  <= 32'd0;
                        takenReg   <= 1'b0;
                        illegalReg <= 1'b0;
                end else begin
                        if (wrEn && offset == regInstr)
                                instr <= pwdata;
                        if (wrEn && offset == regOpA)
                                opA <= pwdata;
                        if (wrEn && offset == regOpB)
                                opB <= pwdata;

                        // A new command restarts even while busy
                        if (cmdWrite) begin
                                busy <= 1'b1;
                                done <= 1'b0;
                        end else if (busy) begin
                                busy       <= 1'b0;
                                done       <= 1'b1;
                                resultReg  <= illegal ? 32'd0 : result;
                                takenReg   <= taken && !illegal;
                                illegalReg <= illegal;
                        end
                end
        end

endmodule

`default_nettype wire

// File: source/mipsExecTop.sv
`timescale 1ns/100ps
`default_nettype none

module mipsExecTop #(
        parameter int addrWidth = 8
) (
        input  logic                 clk,
        input  logic                 rstN,
        input  logic                 psel,
        input  logic                 penable,
        input  logic                 pwrite,
        input  logic [addrWidth-1:0] paddr,
        input  logic [31:0]          pwdata,
        output logic [31:0]          prdata,
        output logic                 pready,
        output logic                 pslverr
);
        import mipsExecPkg::*;

        instrWord    instr;
        logic [31:0] opA;
        logic [31:0] opB;
        aluOpCode    aluOp;
        logic        useImm;
        logic        zeroExt;
        logic        illegal;
        logic [31:0] result;
        logic        taken;

        // APB register block and sequencer
        execCtrl #(
                .addrWidth (addrWidth)
        ) i_execCtrl (
                .clk     (clk),
                .rstN    (rstN),
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .paddr   (paddr),
                .pwdata  (pwdata),
                .prdata  (prdata),
                .pready  (pready),
                .pslverr (pslverr),
                .result  (result),
                .taken   (taken),
                .illegal (illegal),
                .instr   (instr),
                .opA     (opA),
                .opB     (opB)
        );

        // Combinational datapath
        aluController i_aluController (
                .instr   (instr),
                .aluOp   (aluOp),
                .useImm  (useImm),
                .zeroExt (zeroExt),
                .illegal (illegal)
        );

        aluCore i_aluCore (
                .instr   (instr),
                .opA     (opA),
                .opB     (opB),
                .aluOp   (aluOp),
                .useImm  (useImm),
                .zeroExt (zeroExt),
                .result  (result)
        );

        branchUnit i_branchUnit (
                .instr (instr),
                .opA   (opA),
                .opB   (opB),
                .taken (taken)
        );

endmodule

`default_nettype wire

// File: tests/mipsExec_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mipsExec_chk (
        input logic clk,
        input logic rstN,
        input logic psel,
        input logic penable,
        input logic pready,
        input logic pslverr,
        input logic busy,
        input logic done
);

        // Every access phase follows a setup phase
        setupFirst: assert property (@(posedge clk) disable iff (!rstN)
                $rose(penable) |-> $past(psel))
                else $error("penable rose without psel in the previous cycle");

        // Result reads wait one cycle at most
        shortStall: assert property (@(posedge clk) disable iff (!rstN) !pready |=> pready)
                else $error("pready held low for more than one cycle");

        busyDone: assert property (@(posedge clk) disable iff (!rstN) !(busy && done))
                else $error("busy and done high together");

        errWithReady: assert property (@(posedge clk) disable iff (!rstN) pslverr |-> pready)
                else $error("pslverr high while pready is low");

endmodule

bind execCtrl mipsExec_chk i_mipsExecChk (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pready  (pready),
        .pslverr (pslverr),
        .busy    (busy),
        .done    (done)
);

`default_nettype wire

// File: tests/mipsExecTb.sv
`timescale 1ns/100ps
`default_nettype none

module mipsExecTb;
        import mipsExecPkg::*;

        // Wider than the decoded window so upper address bits can be hit
        localparam int addrWidth = 10;

        logic                 clk = 1'b0;
        logic                 rstN;
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [addrWidth-1:0] paddr;
        logic [31:0]          pwdata;
        logic [31:0]          prdata;
        logic                 pready;
        logic                 pslverr;

        logic [31:0] seed;
        logic        testBad;
        logic        timedOut;
        int          passCount;
        int          failCount;

        mipsExecTop #(
                .addrWidth (addrWidth)
        ) i_mipsExecTop (
                .clk     (clk),
                .rstN    (rstN),
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .paddr   (paddr),
                .pwdata  (pwdata),
                .prdata  (prdata),
                .pready  (pready),
                .pslverr (pslverr)
        );

        always #2 clk = ~clk;

        function automatic logic [31:0] nextRandom(input logic [31:0] state);
                return state * 32'd1664525 + 32'd1013904223;
        endfunction

        //////////////////////////////////////////////////////////////////////
        // Compare tasks
        //////////////////////////////////////////////////////////////////////
        task automatic checkWord(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("Error %s expected %h got %h", name, expected, actual);
                        testBad = 1'b1;
                end
        endtask

        task automatic checkStatus(input logic [2:0] expected, input logic [2:0] actual);
                if (actual !== expected) begin
                        $display("Error regStatus expected %h got %h", expected, actual);
                        testBad = 1'b1;
                end
        endtask

        task automatic checkErr(input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("Error pslverr expected %h got %h", expected, actual);
                        testBad = 1'b1;
                end
        endtask

        //////////////////////////////////////////////////////////////////////
        // APB driver, entered and left 0.5 ns after a rising edge
        //////////////////////////////////////////////////////////////////////
        task automatic busTransfer(input logic wr, input logic [addrWidth-1:0] addr,
                                   input logic [31:0] wdata, output logic [31:0] rdata,
                                   output logic err);
                int   waits;
                logic ready;
                waits   = 0;
                ready   = 1'b0;
                rdata   = 32'd0;
                err     = 1'b0;
                psel    = 1'b1;
                penable = 1'b0;
                pwrite  = wr;
                paddr   = addr;
                pwdata  = wdata;
                @(posedge clk);
                #0.5;
                penable = 1'b1;
                // Sample mid-cycle, the transfer completes on the next edge
                while (!ready && waits < 20) begin
                        @(negedge clk);
                        if (pready) begin
                                ready = 1'b1;
                                rdata = prdata;
                                err   = pslverr;
                        end else begin
                                waits++;
                        end
                        @(posedge clk);
                        #0.5;
                end
                psel    = 1'b0;
                penable = 1'b0;
                if (!ready) begin
                        $display("Timeout: pready stayed low for 20 cycles at address %h", addr);
                        timedOut = 1'b1;
                        testBad  = 1'b1;
                end
        endtask

        task automatic writeReg(input logic [7:0] offset, input logic [31:0] data);
                logic [31:0] rdata;
                logic        err;
                busTransfer(1'b1, addrWidth'(offset), data, rdata, err);
                checkErr(1'b0, err);
        endtask

        task automatic readReg(input logic [7:0] offset, output logic [31:0] data);
                logic err;
                busTransfer(1'b0, addrWidth'(offset), 32'd0, data, err);
                checkErr(1'b0, err);
        endtask

        // Zero to three idle cycles
        task automatic idleGap();
                seed = nextRandom(seed);
                repeat (seed[17:16]) begin
                        @(posedge clk);
                        #0.5;
                end
        endtask

        task automatic runCase(input logic [63:0] kind, input instrWord instr,
                               input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] expRes, input logic [31:0] expStat);
                logic [31:0] rdata;
                logic        err;
                if (kind == "err") begin
                        // opA holds the offset, opB bit 0 picks a write
                        writeReg(regInstr, instr);
                        idleGap();
                        busTransfer(b[0], a[addrWidth-1:0], ~instr, rdata, err);
                        checkErr(expStat[0], err);
                        idleGap();
                        readReg(regInstr, rdata);
                        checkWord("regInstr", expRes, rdata);
                end else if (kind == "exec" || kind == "stall") begin
                        writeReg(regInstr, instr);
                        idleGap();
                        writeReg(regOpA, a);
                        idleGap();
                        writeReg(regOpB, b);
                        idleGap();
                        writeReg(regCmd, 32'd1);
                        // Stall cases read right behind the command
                        if (kind == "exec")
                                idleGap();
                        readReg(regResult, rdata);
                        checkWord("regResult", expRes, rdata);
                        idleGap();
                        readReg(regStatus, rdata);
                        checkStatus(expStat[2:0], rdata[2:0]);
                end else begin
                        $display("Unknown case kind %0s in the case file", kind);
                        testBad = 1'b1;
                end
        endtask

        initial begin
                int          fd;
                int          caseNum;
                string       line;
                logic [63:0] kind;
                instrWord    instr;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] expRes;
                logic [31:0] expStat;
                rstN      = 1'b0;
                psel      = 1'b0;
                penable   = 1'b0;
                pwrite    = 1'b0;
                paddr     = '0;
                pwdata    = 32'd0;
                seed      = 32'hbcfc;
                testBad   = 1'b0;
                timedOut  = 1'b0;
                passCount = 0;
                failCount = 0;
                caseNum   = 0;
                repeat (3) @(posedge clk);
                #0.5;
                rstN = 1'b1;

                fd = $fopen("tests/execCases.txt", "r");
                if (fd == 0) begin
                        $display("Could not open tests/execCases.txt");
                end else begin
                        while (!timedOut && $fgets(line, fd) != 0) begin
                                kind = '0;
                                if ($sscanf(line, "%s %h %h %h %h %h", kind, instr, a, b,
                                            expRes, expStat) == 6) begin
                                        caseNum++;
                                        testBad = 1'b0;
                                        runCase(kind, instr, a, b, expRes, expStat);
                                        if (testBad)
                                                failCount++;
                                        else
                                                passCount++;
                                        $display("test %0d %0s opcode %h %0s", caseNum, kind,
                                                 instr.rType.opcode, testBad ? "FAIL" : "ok");
                                end
                        end
                        $fclose(fd);
                end

                $display("tests passed %0d failed %0d", passCount, failCount);
                if (failCount == 0 && passCount > 0 && !timedOut)
                        $display("sim passed");
                else
                        $display("sim failed");
                $finish;
        end

endmodule

`default_nettype wire

// File: tests/execCases.txt
# kind instr opA opB result status, all hex, status bit0 done bit1 taken bit2 illegal
# err lines: opA is the offset, opB 1 for a write, result is regInstr after, status is pslverr
exec 00221820 7FFFFFFF 00000001 80000000 1
exec 00221821 FFFFFFFF 00000002 00000001 1
exec 00221822 00000010 00000020 FFFFFFF0 1
exec 70221802 FFFFFFFE 00000003 FFFFFFFA 1
exec 00221824 F0F0FF00 0FF0F0F0 00F0F000 1
exec 00221825 F0F0FF00 0FF0F0F0 FFF0FFF0 1
exec 00221826 F0F0FF00 0FF0F0F0 FF000FF0 1
exec 00221827 F0F0FF00 0FF0F0F0 000F000F 1
exec 0022182A FFFFFFFF 00000001 00000001 1
exec 0022182B FFFFFFFF 00000001 00000000 1
exec 2022FFFC 00000010 00000000 0000000C 1
exec 3022F0F0 FFFFFFFF 00000000 0000F0F0 1
exec 34228001 12340000 00000000 12348001 1
exec 3822FFFF 0000FF00 00000000 000000FF 1
exec 2822FFFF FFFFFFFE 00000000 00000001 1
exec 2C22FFFF FFFFFFFE 00000000 00000001 1
exec 00021900 00000000 80000001 00000010 1
exec 00021902 00000000 80000010 08000001 1
exec 00021903 00000000 80000010 F8000001 1
exec 00221902 00000000 12345678 81234567 1
exec 00221804 00000024 00000003 00000030 1
exec 00221806 00000008 F0000000 00F00000 1
exec 00221807 00000008 F0000000 FFF00000 1
exec 00221846 00000008 12345678 78123456 1
exec 7C021C20 00000000 00000080 FFFFFF80 1
exec 7C021E20 00000000 12348001 FFFF8001 1
exec 3C02ABCD 00000000 00000000 ABCD0000 1
exec 10220010 00000005 00000005 00000000 3
exec 10220010 00000005 00000006 FFFFFFFF 1
exec 14220010 00000005 00000005 00000000 1
exec 14220010 00000005 00000006 FFFFFFFF 3
exec 04200010 FFFFFFFF 00000000 FFFFFFFF 3
exec 04200010 00000000 00000000 00000000 1
exec 04210010 00000000 00000000 00000000 3
exec 04210010 80000000 00000000 80000000 1
exec 18200010 00000000 00000000 00000000 3
exec 18200010 00000007 00000000 00000007 1
exec 1C200010 00000007 00000000 00000007 3
exec 1C200010 00000000 00000000 00000000 1
exec 1C200010 FFFFFFF0 00000000 FFFFFFF0 1
exec 00220019 11111111 22222222 00000000 5
exec FC000000 11111111 22222222 00000000 5
err 00221820 00000010 00000001 00221820 1
err 00221821 00000014 00000001 00221821 1
err 3C02ABCD 0000000C 00000000 3C02ABCD 1
err 12345678 00000018 00000001 12345678 1
err 0BADF00D 00000100 00000001 0BADF00D 1
stall 70221802 00001234 00000100 00123400 1
stall 10220010 00000009 00000009 00000000 3

// File: files.f
source/mipsExecPkg.sv
source/aluController.sv
source/aluCore.sv
source/branchUnit.sv
source/execCtrl.sv
source/mipsExecTop.sv
tests/mipsExec_chk.sv
tests/mipsExecTb.sv

// File: Makefile
TOP = mipsExecTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f files.f --top-module mipsExecTop
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f files.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
